//--- ilk_tx_pkg.sv
/*
 * Shared definitions for the Interlaken transmit front end
 *   beat geometry and burst limit localparams
 *   Avalon-ST input beat, adapter result, burst flags
 *   control descriptor and Interlaken output beat
 */

package ilk_tx_pkg;

   // beat geometry
   localparam int WORDS = 4;
   localparam int WORD_W = 64;
   localparam int DATA_W = WORDS * WORD_W;

   // empty is a byte count over the whole beat
   localparam int EMPTY_W = 5;
   // word count field, holds 0 to WORDS
   localparam int NV_W = 3;

   // burst is closed once it reaches this many words
   localparam int BURST_MAX = 8;
   // running count never passes BURST_MAX + WORDS
   localparam int CNT_W = $clog2(BURST_MAX + WORDS + 1);

   localparam int CHAN_W = 8;

   // Avalon-ST beat as it enters the framer
   typedef struct packed {
      logic [DATA_W-1:0]  data;
      logic               sop;
      logic               eop;
      logic [EMPTY_W-1:0] empty;
      logic               error;
   } avl_beat_t;

   // decoded word count and eop encoding
   typedef struct packed {
      logic [NV_W-1:0] num_valid;
      logic [3:0]      eopbits;
   } ilk_code_t;

   // burst boundaries for the present beat
   typedef struct packed {
      logic burst_start;
      logic burst_end;
   } burst_flags_t;

   // burst control descriptor
   typedef struct packed {
      logic              burst_start;
      logic              burst_end;
      logic              sop;
      logic [3:0]        eopbits;
      logic [CHAN_W-1:0] channel;
   } ilk_ctrl_t;

   // Interlaken beat leaving the framer
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [NV_W-1:0]   num_valid;
      logic              sop;
      logic [3:0]        eopbits;
      ilk_ctrl_t         ctrl;
   } ilk_beat_t;

endpackage

//--- avl_to_ilk_adapter.sv
/*
 * Avalon-ST to Interlaken beat decoder
 *   empty and eop map to a valid word count
 *   eop, empty and error map to Interlaken eop bits
 */

`timescale 1ns/1ps

module avl_to_ilk_adapter import ilk_tx_pkg::*; (
   input  avl_beat_t avl_beat,
   output ilk_code_t code
);

   // unused bytes in the last word
   logic [2:0] byte_pos;

   assign byte_pos = avl_beat.empty[2:0];

   always_comb begin
      code.num_valid = '0;
      code.eopbits = 4'b0000;

      if (!avl_beat.eop) begin
         // mid-packet beat needs a word aligned empty
         case (avl_beat.empty)
            5'd0: code.num_valid = 3'd4;
            5'd8: code.num_valid = 3'd3;
            5'd16: code.num_valid = 3'd2;
            5'd24: code.num_valid = 3'd1;
            // unaligned empty without eop carries no words
            default: code.num_valid = 3'd0;
         endcase
      end else begin
         // a partial last word still counts
         if (avl_beat.empty < 5'd8) begin
            code.num_valid = 3'd4;
         end else if (avl_beat.empty < 5'd16) begin
            code.num_valid = 3'd3;
         end else if (avl_beat.empty < 5'd24) begin
            code.num_valid = 3'd2;
         end else begin
            code.num_valid = 3'd1;
         end

         if (avl_beat.error) begin
            // error end of packet ignores empty
            code.eopbits = 4'b0001;
         end else begin
            // msb marks eop and low bits give valid bytes in the last word
            // 0 empty bytes wraps to 000 for all eight
            code.eopbits = {1'b1, 3'(3'd0 - byte_pos)};
         end
      end
   end

endmodule

//--- ilk_burst_tracker.sv
/*
 * Burst boundary tracker
 *   running word count of the open burst
 *   start and end flags for the present beat
 */

`timescale 1ns/1ps

module ilk_burst_tracker import ilk_tx_pkg::*; (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            accept,
   input  logic            eop,
   input  logic [NV_W-1:0] num_valid,
   output burst_flags_t    flags
);

   // words already sent in the open burst
   logic [CNT_W-1:0] count;
   // a burst has started and not yet ended
   logic             burst_open;
   // one bit wider count including the present beat
   logic [CNT_W:0]   count_sum;

   assign count_sum = (CNT_W+1)'(count) + (CNT_W+1)'(num_valid);

   // first beat after reset or after an end opens a burst
   assign flags.burst_start = !burst_open;
   // close on packet end or once the burst is full
   assign flags.burst_end = eop || (count_sum >= (CNT_W+1)'(BURST_MAX));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count <= '0;
         burst_open <= 1'b0;
      end else if (accept) begin
         if (flags.burst_end) begin
            count <= '0;
            burst_open <= 1'b0;
         end else begin
            // sum is below BURST_MAX here and fits in CNT_W
            count <= count_sum[CNT_W-1:0];
            burst_open <= 1'b1;
         end
      end
   end

   // count stays bounded across any run of accepted beats
   a_count_bound: assert property (
      @(posedge clk) disable iff (!rst_n)
      count <= CNT_W'(BURST_MAX + WORDS)
   ) else $error("burst count %0d above limit", count);

endmodule

//--- ilk_beat_assembler.sv
/*
 * Interlaken output beat register
 *   accept and ready generation with back-pressure
 *   one registered beat with its control descriptor
 */

`timescale 1ns/1ps

module ilk_beat_assembler import ilk_tx_pkg::*; (
   input  logic         clk,
   input  logic         rst_n,
   input  avl_beat_t    avl_beat,
   input  logic         avl_valid,
   output logic         avl_ready,
   input  ilk_code_t    code,
   input  burst_flags_t flags,
   output logic         accept,
   output ilk_beat_t    ilk_beat,
   output logic         ilk_valid,
   input  logic         ilk_ready
);

   ilk_beat_t next_beat;

   // room when the register is empty or drains this cycle
   assign avl_ready = !ilk_valid || ilk_ready;
   assign accept = avl_valid && avl_ready;

   // control descriptor, single channel
   always_comb begin
      next_beat.data = avl_beat.data;
      next_beat.num_valid = code.num_valid;
      next_beat.sop = avl_beat.sop;
      next_beat.eopbits = code.eopbits;
      next_beat.ctrl.burst_start = flags.burst_start;
      next_beat.ctrl.burst_end = flags.burst_end;
      next_beat.ctrl.sop = avl_beat.sop;
      next_beat.ctrl.eopbits = code.eopbits;
      next_beat.ctrl.channel = '0;
   end

   // valid flag
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ilk_valid <= 1'b0;
      end else if (accept) begin
         ilk_valid <= 1'b1;
      end else if (ilk_ready) begin
         // drained with nothing new behind it
         ilk_valid <= 1'b0;
      end
   end

   // payload only loads on accept, holds under back-pressure
   always_ff @(posedge clk) begin
      if (accept) begin
         ilk_beat <= next_beat;
      end
   end

   // held beat must not change until the sink takes it
   a_hold_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      ilk_valid && !ilk_ready |=> ilk_valid && $stable(ilk_beat)
   ) else $error("output beat changed under back-pressure");

   // any eop encoding carries at least one word
   a_eop_has_words: assert property (
      @(posedge clk) disable iff (!rst_n)
      ilk_valid && (ilk_beat.eopbits != 4'b0000) |-> ilk_beat.num_valid != '0
   ) else $error("eop beat with zero words");

endmodule

//--- ilk_tx_framer.sv
/*
 * Interlaken transmit framer top level
 *   adapter, burst tracker and beat assembler
 */

`timescale 1ns/1ps

module ilk_tx_framer import ilk_tx_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   // Avalon-ST side
   input  avl_beat_t avl_beat,
   input  logic      avl_valid,
   output logic      avl_ready,
   // Interlaken side
   output ilk_beat_t ilk_beat,
   output logic      ilk_valid,
   input  logic      ilk_ready
);

   ilk_code_t    code;
   burst_flags_t flags;
   logic         accept;

   // word count and eop bits, combinational
   avl_to_ilk_adapter u_adapter (
      .avl_beat (avl_beat),
      .code     (code)
   );

   // burst flags, advances only on accept
   ilk_burst_tracker u_tracker (
      .clk       (clk),
      .rst_n     (rst_n),
      .accept    (accept),
      .eop       (avl_beat.eop),
      .num_valid (code.num_valid),
      .flags     (flags)
   );

   // output register and handshake
   ilk_beat_assembler u_assembler (
      .clk       (clk),
      .rst_n     (rst_n),
      .avl_beat  (avl_beat),
      .avl_valid (avl_valid),
      .avl_ready (avl_ready),
      .code      (code),
      .flags     (flags),
      .accept    (accept),
      .ilk_beat  (ilk_beat),
      .ilk_valid (ilk_valid),
      .ilk_ready (ilk_ready)
   );

endmodule

//--- tb_ilk_tx_framer.sv
/*
 * Testbench for the Interlaken transmit framer
 *   random Avalon beats and random sink back-pressure
 *   reference model feeding an expected-beat queue
 *   concurrent checks on reset, handshake and hold, plus a watchdog
 */

`timescale 1ns/1ps

module tb_ilk_tx_framer import ilk_tx_pkg::*; ();

   localparam int CLK_PERIOD = 4;
   localparam int RESET_CYCLES = 5;
   localparam int NUM_BEATS = 2000;
   // ten cycles per beat is far above the average handshake rate
   localparam int TIMEOUT_NS = NUM_BEATS * 10 * CLK_PERIOD;

   logic        clk;
   logic        rst_n;
   avl_beat_t   avl_beat;
   logic        avl_valid;
   logic        avl_ready;
   ilk_beat_t   ilk_beat;
   logic        ilk_valid;
   logic        ilk_ready;

   integer      seed = 32'h5824;
   int          errors = 0;
   int          beats_sent = 0;
   int          beats_in = 0;
   int          beats_out = 0;

   // expected output beats in accept order
   ilk_beat_t   exp_q[$];
   // model of the open burst
   int          model_count = 0;
   logic        model_open = 1'b0;
   logic        model_end;
   // next generated beat is still inside a packet
   logic        in_packet = 1'b0;
   logic [31:0] drv_rnd;
   avl_beat_t   drv_beat;

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   ilk_tx_framer uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .avl_beat  (avl_beat),
      .avl_valid (avl_valid),
      .avl_ready (avl_ready),
      .ilk_beat  (ilk_beat),
      .ilk_valid (ilk_valid),
      .ilk_ready (ilk_ready)
   );

   // words carried, empty counts unused bytes of the 32-byte beat
   function automatic logic [NV_W-1:0] words_in_beat(avl_beat_t b);
      // mid-packet beats only count when empty is word aligned
      if (!b.eop && b.empty[2:0] != 3'd0) begin
         return '0;
      end
      return NV_W'(4 - int'(b.empty) / 8);
   endfunction

   function automatic logic [3:0] eop_code(avl_beat_t b);
      logic [2:0] low;
      low = b.empty[2:0];
      if (!b.eop) begin
         return 4'b0000;
      end
      if (b.error) begin
         return 4'b0001;
      end
      if (low == 3'd0) begin
         return 4'b1000;
      end
      return 4'b1000 + 4'(8 - int'(low));
   endfunction

   function automatic ilk_beat_t expected_beat(avl_beat_t b, logic start, logic fin);
      ilk_beat_t e;
      e.data = b.data;
      e.num_valid = words_in_beat(b);
      e.sop = b.sop;
      e.eopbits = eop_code(b);
      e.ctrl.burst_start = start;
      e.ctrl.burst_end = fin;
      e.ctrl.sop = b.sop;
      e.ctrl.eopbits = e.eopbits;
      e.ctrl.channel = '0;
      return e;
   endfunction

   // random payload, eop one beat in four, error on a quarter of those
   task automatic make_beat(output avl_beat_t b);
      logic [31:0] r;
      r = $random(seed);
      for (int i = 0; i < DATA_W / 32; i++) begin
         b.data[i*32 +: 32] = $random(seed);
      end
      b.sop = 1'b0;
      b.eop = (r[1:0] == 2'b00);
      b.error = b.eop && (r[3:2] == 2'b00);
      // mostly aligned mid-packet empty so bursts can fill up
      if (b.eop || r[6:4] == 3'b000) begin
         b.empty = r[12:8];
      end else begin
         b.empty = {r[9:8], 3'b000};
      end
   endtask

   task automatic compare_beat(input ilk_beat_t exp, input ilk_beat_t got);
      assert (got.data == exp.data && got.sop == exp.sop)
      else begin
         errors++;
         $display("FAIL %0t: beat %0d data or sop differs from input", $time, beats_out);
      end
      assert (got.num_valid == exp.num_valid)
      else begin
         errors++;
         $display("FAIL %0t: beat %0d num_valid %0d, expected %0d",
                  $time, beats_out, got.num_valid, exp.num_valid);
      end
      assert (got.eopbits == exp.eopbits)
      else begin
         errors++;
         $display("FAIL %0t: beat %0d eopbits %b, expected %b",
                  $time, beats_out, got.eopbits, exp.eopbits);
      end
      assert (got.ctrl.burst_start == exp.ctrl.burst_start &&
              got.ctrl.burst_end == exp.ctrl.burst_end)
      else begin
         errors++;
         $display("FAIL %0t: beat %0d burst start/end %b%b, expected %b%b", $time, beats_out,
                  got.ctrl.burst_start, got.ctrl.burst_end,
                  exp.ctrl.burst_start, exp.ctrl.burst_end);
      end
      assert (got.ctrl.sop == exp.ctrl.sop && got.ctrl.eopbits == exp.ctrl.eopbits &&
              got.ctrl.channel == exp.ctrl.channel)
      else begin
         errors++;
         $display("FAIL %0t: beat %0d control descriptor sop/eopbits/channel wrong",
                  $time, beats_out);
      end
   endtask

   // driver, holds a beat until it is taken
   always @(posedge clk) begin
      if (rst_n) begin
         if (!avl_valid || avl_ready) begin
            drv_rnd = $random(seed);
            if (beats_sent < NUM_BEATS && drv_rnd[1:0] != 2'b00) begin
               make_beat(drv_beat);
               drv_beat.sop = !in_packet;
               in_packet = !drv_beat.eop;
               avl_beat <= drv_beat;
               avl_valid <= 1'b1;
               beats_sent++;
            end else begin
               avl_valid <= 1'b0;
            end
         end
         // sink stalls about one cycle in four
         drv_rnd = $random(seed);
         ilk_ready <= (drv_rnd[1:0] != 2'b00);
      end
   end

   // reference model, sampled mid-cycle where handshakes are settled
   always @(negedge clk) begin
      if (rst_n) begin
         // held output beat is older than any beat accepted now
         if (ilk_valid && ilk_ready) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("output beat %0d at %0t has no accepted input beat behind it",
                        beats_out, $time);
            end else begin
               compare_beat(exp_q.pop_front(), ilk_beat);
            end
            beats_out++;
         end
         if (avl_valid && avl_ready) begin
            model_end = avl_beat.eop ||
                        (model_count + int'(words_in_beat(avl_beat)) >= BURST_MAX);
            exp_q.push_back(expected_beat(avl_beat, !model_open, model_end));
            if (model_end) begin
               model_count = 0;
               model_open = 1'b0;
            end else begin
               model_count += int'(words_in_beat(avl_beat));
               model_open = 1'b1;
            end
            beats_in++;
         end
      end else begin
         model_count = 0;
         model_open = 1'b0;
      end
   end

   // output register empty after reset
   reset_check: assert property (@(posedge clk) !rst_n |=> !ilk_valid)
   else begin
      errors++;
      $display("FAIL %0t: ilk_valid high after reset", $time);
   end

   // held beat frozen while the sink stalls
   hold_check: assert property (@(posedge clk) disable iff (!rst_n)
      ilk_valid && !ilk_ready |=> ilk_valid && $stable(ilk_beat))
   else begin
      errors++;
      $display("FAIL %0t: output beat changed under back-pressure", $time);
   end

   ready_check: assert property (@(posedge clk) disable iff (!rst_n)
      avl_ready == (!ilk_valid || ilk_ready))
   else begin
      errors++;
      $display("FAIL %0t: avl_ready %b with ilk_valid %b ilk_ready %b",
               $time, avl_ready, ilk_valid, ilk_ready);
   end

   // watchdog
   initial begin
      #(TIMEOUT_NS + RESET_CYCLES * CLK_PERIOD);
      $display("timeout, only %0d of %0d beats came out", beats_out, NUM_BEATS);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      rst_n = 1'b0;
      avl_valid = 1'b0;
      avl_beat = '0;
      ilk_ready = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      wait (beats_out == NUM_BEATS);
      // a few idle cycles catch duplicated beats
      repeat (10) @(posedge clk);
      if (exp_q.size() != 0) begin
         errors++;
         $display("%0d accepted input beats never reached the output", exp_q.size());
      end
      $display("beats in %0d, beats out %0d, errors %0d", beats_in, beats_out, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- project.f
ilk_tx_pkg.sv
avl_to_ilk_adapter.sv
ilk_burst_tracker.sv
ilk_beat_assembler.sv
ilk_tx_framer.sv
tb_ilk_tx_framer.sv

//--- Makefile
# Verilator build and run for the Interlaken transmit framer

VERILATOR ?= verilator
TOP       ?= tb_ilk_tx_framer
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
